/* vlog.f */
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/int_alu.sv
hdl/int_decoder.sv
hdl/int_regfile.sv
hdl/int_exec_stage.sv
hdl/int_core_top.sv
bench/int_core_assert.sv
bench/int_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the integer core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module int_core_tb \
  -o Vint_core_tb \
  && ./obj_dir/Vint_core_tb | tee /dev/stderr | grep -q "Test completed successfully" \
  && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }

/* bench/int_core_tb.sv */
// int_core_tb: clock, reset, watchdog, reference model, checks and directed tests
`timescale 1ns/1ps
`default_nettype none

module int_core_tb;

  // commit is sampled one edge after it is registered
  localparam int SAMPLE_LAT = 3;

  logic                 clk = 1'b0;
  logic                 rst = 1'b1;
  logic                 i_inst_valid = 1'b0;
  rv_isa_pkg::inst_u    i_inst = '0;
  rv_isa_pkg::reg_idx_t i_dbg_idx = '0;
  logic                 o_commit_valid;
  core_pkg::commit_t    o_commit;
  logic [63:0]          o_dbg_data;

  logic [63:0]       model [32];
  core_pkg::commit_t exp_q [$];
  int                cyc_q [$];
  int                cyc = 0;
  int                n_issued = 0;
  int                n_scans = 0;
  int                n_checks = 0;
  int                errors = 0;

  int_core_top #(.NUM_REGS(32)) u_int_core_top (
    .clk            (clk),
    .rst            (rst),
    .i_inst_valid   (i_inst_valid),
    .i_inst         (i_inst),
    .i_dbg_idx      (i_dbg_idx),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit),
    .o_dbg_data     (o_dbg_data)
  );

  always #4 clk = ~clk;

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'h37};
  endfunction

  // in-order reference model, updated when the instruction is issued
  function automatic core_pkg::commit_t predict(input logic [31:0] w);
    core_pkg::commit_t e;
    logic [63:0]       a;
    logic [63:0]       b;
    logic [63:0]       r;
    logic [2:0]        f3;
    logic              alt;
    logic              ok;
    f3 = w[14:12];
    a = model[w[19:15]];
    b = (w[6:0] == 7'h13) ? sext12(w[31:20]) : model[w[24:20]];
    r = '0;
    ok = 1'b1;
    alt = 1'b0;
    if (w[6:0] == 7'h37) begin
      r = {{32{w[31]}}, w[31:12], 12'h000};
    end else if (w[6:0] == 7'h33 || w[6:0] == 7'h13) begin
      if (w[6:0] == 7'h33) begin
        alt = (w[31:25] == 7'h20);
        ok = (w[31:25] == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
      end else if (f3 == 3'd1) begin
        ok = (w[31:26] == 6'h00);
      end else if (f3 == 3'd5) begin
        alt = w[30];
        ok = (w[31:26] == 6'h00) || (w[31:26] == 6'h10);
      end
      case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[5:0];
        3'd2: r = {63'd0, $signed(a) < $signed(b)};
        3'd3: r = {63'd0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
          // arithmetic shift kept out of a mixed-sign expression
          if (alt) begin
            r = $signed(a) >>> b[5:0];
          end else begin
            r = a >> b[5:0];
          end
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
    end else begin
      ok = 1'b0;
    end
    e.rd = w[11:7];
    e.rd_wen = ok;
    e.data = r;
    e.illegal = !ok;
    if (ok && w[11:7] != 5'd0) begin
      model[w[11:7]] = r;
    end
    return e;
  endfunction

  task automatic issue(input logic [31:0] w);
    core_pkg::commit_t e;
    e = predict(w);
    @(posedge clk);
    #1;
    i_inst_valid = 1'b1;
    i_inst = w;
    exp_q.push_back(e);
    cyc_q.push_back(cyc);
    n_issued++;
  endtask

  task automatic drain();
    @(posedge clk);
    #1;
    i_inst_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic check_commit();
    core_pkg::commit_t e;
    int                c;
    if (exp_q.size() == 0) begin
      errors++;
      $display("commit pulse at %0t with no instruction outstanding", $time);
    end else begin
      e = exp_q.pop_front();
      c = cyc_q.pop_front();
      compare("commit latency", 64'(cyc - c), 64'(SAMPLE_LAT));
      compare("o_commit.illegal", 64'(o_commit.illegal), 64'(e.illegal));
      compare("o_commit.rd_wen", 64'(o_commit.rd_wen), 64'(e.rd_wen));
      if (!e.illegal) begin
        compare("o_commit.rd", 64'(o_commit.rd), 64'(e.rd));
        compare("o_commit.data", o_commit.data, e.data);
      end
    end
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rst && o_commit_valid) begin
      check_commit();
    end
  end

  task automatic dbg_scan();
    for (int i = 0; i < 32; i++) begin
      @(posedge clk);
      #1;
      i_dbg_idx = 5'(i);
      @(posedge clk);
      compare("o_dbg_data", o_dbg_data, model[i]);
    end
    n_scans++;
  endtask

  task automatic reset_defaults();
    repeat (10) @(posedge clk);
    dbg_scan();
  endtask

  task automatic op_imm_group();
    logic [31:0] r;
    logic [11:0] imm;
    for (int i = 1; i < 32; i++) begin
      r = $urandom;
      issue(enc_u(r[19:0], 5'(i)));
      issue(enc_i(r[31:20], 5'(i), 3'd0, 5'(i)));
    end
    for (int i = 0; i < 60; i++) begin
      r = $urandom;
      imm = r[31:20];
      // shifts carry a 6-bit shamt under funct6
      if (r[2:0] == 3'd1) imm = {6'h00, r[25:20]};
      if (r[2:0] == 3'd5) imm = {(r[26] ? 6'h10 : 6'h00), r[25:20]};
      issue(enc_i(imm, r[12:8], r[2:0], (r[17:13] == 5'd0) ? 5'd1 : r[17:13]));
    end
    drain();
  endtask

  task automatic r_type_group();
    logic [31:0] r;
    logic [6:0]  f7;
    // sign boundary values in x1..x5
    issue(enc_i(12'd1, 5'd0, 3'd0, 5'd1));
    issue(enc_i(12'd63, 5'd1, 3'd1, 5'd1));
    issue(enc_i(12'hfff, 5'd0, 3'd0, 5'd2));
    issue(enc_i(12'd0, 5'd0, 3'd0, 5'd3));
    issue(enc_u(20'h80000, 5'd4));
    issue(enc_i(12'd1, 5'd2, 3'd5, 5'd5));
    for (int a = 1; a <= 5; a++) begin
      for (int b = 1; b <= 5; b++) begin
        issue(enc_r(7'h20, 5'(b), 5'(a), 3'd0, 5'd10));
        issue(enc_r(7'h20, 5'(b), 5'(a), 3'd5, 5'd11));
        issue(enc_r(7'h00, 5'(b), 5'(a), 3'd2, 5'd12));
        issue(enc_r(7'h00, 5'(b), 5'(a), 3'd3, 5'd13));
      end
    end
    for (int i = 0; i < 40; i++) begin
      r = $urandom;
      f7 = (r[30] && (r[2:0] == 3'd0 || r[2:0] == 3'd5)) ? 7'h20 : 7'h00;
      issue(enc_r(f7, r[24:20], r[12:8], r[2:0], (r[17:13] == 5'd0) ? 5'd14 : r[17:13]));
    end
    drain();
  endtask

  task automatic dependent_chain();
    logic [31:0] r;
    for (int i = 0; i < 16; i++) begin
      r = $urandom;
      issue(enc_i(r[11:0], 5'd6, 3'd0, 5'd6));
      issue(enc_r(7'h00, 5'd7, 5'd6, 3'd0, 5'd7));
      issue(enc_r(7'h00, 5'd6, 5'd7, 3'd4, 5'd6));
      issue(enc_r(7'h20, 5'd6, 5'd7, 3'd5, 5'd8));
    end
    drain();
  endtask

  task automatic x0_writes();
    issue(enc_i(12'h123, 5'd1, 3'd0, 5'd0));
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
    issue(enc_u(20'habcde, 5'd0));
    issue(enc_r(7'h20, 5'd1, 5'd0, 3'd0, 5'd9));
    drain();
    dbg_scan();
  endtask

  task automatic illegal_encodings();
    issue(32'hffff_ffff);
    issue(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd3));
    issue(enc_r(7'h20, 5'd2, 5'd1, 3'd1, 5'd3));
    issue(enc_i({6'h10, 6'd3}, 5'd1, 3'd1, 5'd4));
    issue(enc_i({6'h11, 6'd3}, 5'd1, 3'd5, 5'd4));
    issue({12'h000, 5'd1, 3'd3, 5'd5, 7'h03});
    drain();
    dbg_scan();
  endtask

  // limit grows with the issued instructions and the debug scans
  initial begin
    forever begin
      @(posedge clk);
      if (cyc > 20 * n_issued + 200 + 70 * (n_scans + 1)) begin
        $display("watchdog expired at %0t, the DUT stopped committing", $time);
        $display("Test failed");
        $finish;
      end
    end
  end

  initial begin
    void'($urandom(71));
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_defaults();
    op_imm_group();
    r_type_group();
    dependent_chain();
    x0_writes();
    illegal_encodings();
    repeat (4) @(posedge clk);
    $display("checks: %0d  errors: %0d", n_checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/int_core_assert.sv */
// int_core_assert: concurrent checks on stored x0 and the commit outputs
`timescale 1ns/1ps
`default_nettype none

module int_core_assert (
  input logic                        clk,
  input logic                        rst,
  input logic [rv_isa_pkg::XLEN-1:0] i_x0,
  input logic                        i_commit_valid,
  input core_pkg::commit_t           i_commit
);

  // x0 storage never holds a nonzero value
  x0_zero: assert property (@(posedge clk) disable iff (rst) i_x0 == '0)
    else $error("stored x0 is nonzero");

  // reset clears the commit strobe by the next edge
  no_commit_in_reset: assert property (@(posedge clk) rst |=> !i_commit_valid)
    else $error("commit strobe active during reset");

  no_write_on_illegal: assert property (@(posedge clk) disable iff (rst)
    (i_commit_valid && i_commit.illegal) |-> !i_commit.rd_wen)
    else $error("illegal commit with rd_wen set");

endmodule

// stored x0 from the register file, commit record from the execute stage
bind int_core_top int_core_assert u_core_assert (
  .clk            (clk),
  .rst            (rst),
  .i_x0           (u_int_regfile.regs[0]),
  .i_commit_valid (o_commit_valid),
  .i_commit       (o_commit)
);

`default_nettype wire

/* hdl/int_core_top.sv */
// int_core_top: decoder, register file and execute stage of the integer slice
`timescale 1ns/1ps
`default_nettype none

module int_core_top #(
  parameter int NUM_REGS = 32
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_inst_valid,
  input  rv_isa_pkg::inst_u           i_inst,
  input  rv_isa_pkg::reg_idx_t        i_dbg_idx,
  output logic                        o_commit_valid,
  output core_pkg::commit_t           o_commit,
  output logic [rv_isa_pkg::XLEN-1:0] o_dbg_data
);

  core_pkg::dec_t              dec;
  logic [rv_isa_pkg::XLEN-1:0] rs1_data;
  logic [rv_isa_pkg::XLEN-1:0] rs2_data;
  logic                        wr_en;
  rv_isa_pkg::reg_idx_t        wr_idx;
  logic [rv_isa_pkg::XLEN-1:0] wr_data;

  int_decoder #(
    .NUM_REGS (NUM_REGS)
  ) u_int_decoder (
    .i_inst (i_inst),
    .o_dec  (dec)
  );

  // read ports in stage 1, write port from stage 2
  int_regfile #(
    .NUM_REGS (NUM_REGS)
  ) u_int_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (dec.rs1),
    .i_rs2      (dec.rs2),
    .i_rs1_ren  (dec.rs1_ren),
    .i_rs2_ren  (dec.rs2_ren),
    .i_rd       (wr_idx),
    .i_rd_wen   (wr_en),
    .i_rd_data  (wr_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_dbg_idx  (i_dbg_idx),
    .o_dbg_data (o_dbg_data)
  );

  int_exec_stage u_int_exec_stage (
    .clk            (clk),
    .rst            (rst),
    .i_valid        (i_inst_valid),
    .i_dec          (dec),
    .i_rs1_data     (rs1_data),
    .i_rs2_data     (rs2_data),
    .o_wr_en        (wr_en),
    .o_wr_idx       (wr_idx),
    .o_wr_data      (wr_data),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit)
  );

endmodule

`default_nettype wire

/* hdl/int_exec_stage.sv */
// int_exec_stage: stage-2 register, ALU operand select, writeback and commit record
`timescale 1ns/1ps
`default_nettype none

module int_exec_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_valid,
  input  core_pkg::dec_t              i_dec,
  input  logic [rv_isa_pkg::XLEN-1:0] i_rs1_data,
  input  logic [rv_isa_pkg::XLEN-1:0] i_rs2_data,
  output logic                        o_wr_en,
  output rv_isa_pkg::reg_idx_t        o_wr_idx,
  output logic [rv_isa_pkg::XLEN-1:0] o_wr_data,
  output logic                        o_commit_valid,
  output core_pkg::commit_t           o_commit
);

  logic                        s2_valid;
  core_pkg::dec_t              s2_dec;
  logic [rv_isa_pkg::XLEN-1:0] s2_rs1;
  logic [rv_isa_pkg::XLEN-1:0] s2_rs2;
  logic [rv_isa_pkg::XLEN-1:0] alu_b;
  logic [rv_isa_pkg::XLEN-1:0] alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= i_valid;
    end
  end

  // payload follows valid, no reset needed
  always_ff @(posedge clk) begin
    s2_dec <= i_dec;
    s2_rs1 <= i_rs1_data;
    s2_rs2 <= i_rs2_data;
  end

  // immediate covers OP-IMM and the LUI U-immediate
  assign alu_b = s2_dec.use_imm ? s2_dec.imm : s2_rs2;

  int_alu u_int_alu (
    .i_op     (s2_dec.alu_op),
    .i_a      (s2_rs1),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  assign o_wr_en   = s2_valid && s2_dec.rd_wen;
  assign o_wr_idx  = s2_dec.rd;
  assign o_wr_data = alu_result;

  // commit lands on the same edge as the register write
  always_ff @(posedge clk) begin
    if (rst) begin
      o_commit_valid <= 1'b0;
      o_commit       <= '0;
    end else begin
      o_commit_valid   <= s2_valid;
      o_commit.rd      <= s2_dec.rd;
      o_commit.rd_wen  <= s2_dec.rd_wen;
      o_commit.data    <= alu_result;
      o_commit.illegal <= s2_dec.illegal;
    end
  end

endmodule

`default_nettype wire

/* hdl/int_regfile.sv */
// int_regfile: 64-bit register file, x0 fixed at zero, forwarding read ports, debug port
`timescale 1ns/1ps
`default_nettype none

module int_regfile #(
  parameter int NUM_REGS = 32
) (
  input  logic                        clk,
  input  logic                        rst,
  input  rv_isa_pkg::reg_idx_t        i_rs1,
  input  rv_isa_pkg::reg_idx_t        i_rs2,
  input  logic                        i_rs1_ren,
  input  logic                        i_rs2_ren,
  input  rv_isa_pkg::reg_idx_t        i_rd,
  input  logic                        i_rd_wen,
  input  logic [rv_isa_pkg::XLEN-1:0] i_rd_data,
  output logic [rv_isa_pkg::XLEN-1:0] o_rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0] o_rs2_data,
  input  rv_isa_pkg::reg_idx_t        i_dbg_idx,
  output logic [rv_isa_pkg::XLEN-1:0] o_dbg_data
);

  logic [rv_isa_pkg::XLEN-1:0] regs [NUM_REGS];
  logic                        wr_hit;

  // indices past NUM_REGS read as zero
  function automatic logic [rv_isa_pkg::XLEN-1:0] stored(input rv_isa_pkg::reg_idx_t idx);
    logic [rv_isa_pkg::XLEN-1:0] val;
    val = '0;
    if (int'(idx) < NUM_REGS) begin
      val = regs[idx];
    end
    return val;
  endfunction

  // pending write visible on the read ports in the same cycle
  function automatic logic [rv_isa_pkg::XLEN-1:0] read_port(input rv_isa_pkg::reg_idx_t idx,
                                                              input logic ren);
    logic [rv_isa_pkg::XLEN-1:0] val;
    val = '0;
    if (ren) begin
      val = (wr_hit && (idx == i_rd)) ? i_rd_data : stored(idx);
    end
    return val;
  endfunction

  assign wr_hit = i_rd_wen && (i_rd != '0) && (int'(i_rd) < NUM_REGS);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  always_comb begin
    o_rs1_data = read_port(i_rs1, i_rs1_ren);
    o_rs2_data = read_port(i_rs2, i_rs2_ren);
    // stored contents only, no bypass
    o_dbg_data = stored(i_dbg_idx);
  end

endmodule

`default_nettype wire

/* hdl/int_decoder.sv */
// int_decoder: instruction word to decoded fields, immediates and legality
`timescale 1ns/1ps
`default_nettype none

module int_decoder #(
  parameter int NUM_REGS = 32
) (
  input  rv_isa_pkg::inst_u i_inst,
  output core_pkg::dec_t    o_dec
);

  logic [rv_isa_pkg::XLEN-1:0] imm_i;
  logic [rv_isa_pkg::XLEN-1:0] imm_u;
  logic                        f7_base;
  logic                        f7_alt;
  logic                        sh_base;
  logic                        sh_alt;
  logic                        known;
  logic                        bad_idx;

  // funct3 plus the alt bit picks the ALU operation
  function automatic core_pkg::alu_op_e f3_to_op(input logic [2:0] funct3, input logic alt);
    core_pkg::alu_op_e op;
    case (funct3)
      rv_isa_pkg::F3_ADD_SUB: op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     op = core_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     op = core_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    op = core_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     op = core_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      op = core_pkg::ALU_OR;
      default:                op = core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // sign-extended immediates
  assign imm_i = {{(rv_isa_pkg::XLEN-12){i_inst.i_view.imm12[11]}}, i_inst.i_view.imm12};
  assign imm_u = {{(rv_isa_pkg::XLEN-32){i_inst.i_view.imm12[11]}}, i_inst.i_view.imm12,
                  i_inst.i_view.rs1, i_inst.i_view.funct3, 12'b0};

  assign f7_base = (i_inst.r_view.funct7 == rv_isa_pkg::F7_BASE);
  assign f7_alt  = (i_inst.r_view.funct7 == rv_isa_pkg::F7_ALT);
  // RV64 shift immediates keep a 6-bit shamt, upper six bits act as funct6
  assign sh_base = (i_inst.r_view.funct7[6:1] == rv_isa_pkg::F7_BASE[6:1]);
  assign sh_alt  = (i_inst.r_view.funct7[6:1] == rv_isa_pkg::F7_ALT[6:1]);

  always_comb begin
    o_dec        = '0;
    o_dec.alu_op = core_pkg::ALU_ADD;
    known        = 1'b0;
    case (i_inst.r_view.opcode)
      rv_isa_pkg::OPC_OP: begin
        o_dec.rs1     = i_inst.r_view.rs1;
        o_dec.rs1_ren = 1'b1;
        o_dec.rs2     = i_inst.r_view.rs2;
        o_dec.rs2_ren = 1'b1;
        o_dec.rd      = i_inst.r_view.rd;
        o_dec.rd_wen  = 1'b1;
        o_dec.alu_op  = f3_to_op(i_inst.r_view.funct3, f7_alt);
        if ((i_inst.r_view.funct3 == rv_isa_pkg::F3_ADD_SUB) ||
            (i_inst.r_view.funct3 == rv_isa_pkg::F3_SRL_SRA)) begin
          known = f7_base || f7_alt;
        end else begin
          known = f7_base;
        end
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        o_dec.rs1     = i_inst.i_view.rs1;
        o_dec.rs1_ren = 1'b1;
        o_dec.rd      = i_inst.i_view.rd;
        o_dec.rd_wen  = 1'b1;
        o_dec.use_imm = 1'b1;
        o_dec.imm     = imm_i;
        // imm bit 10 only means SRA for the right shift
        o_dec.alu_op  = f3_to_op(i_inst.i_view.funct3,
                                 (i_inst.i_view.funct3 == rv_isa_pkg::F3_SRL_SRA) &&
                                 i_inst.r_view.funct7[5]);
        case (i_inst.i_view.funct3)
          rv_isa_pkg::F3_SLL:     known = sh_base;
          rv_isa_pkg::F3_SRL_SRA: known = sh_base || sh_alt;
          default:                known = 1'b1;
        endcase
      end
      rv_isa_pkg::OPC_LUI: begin
        o_dec.rd      = i_inst.i_view.rd;
        o_dec.rd_wen  = 1'b1;
        o_dec.use_imm = 1'b1;
        o_dec.imm     = imm_u;
        o_dec.alu_op  = core_pkg::ALU_PASS_B;
        known         = 1'b1;
      end
      default: begin
        known = 1'b0;
      end
    endcase

    bad_idx = (int'(o_dec.rd) >= NUM_REGS) ||
              (o_dec.rs1_ren && (int'(o_dec.rs1) >= NUM_REGS)) ||
              (o_dec.rs2_ren && (int'(o_dec.rs2) >= NUM_REGS));

    // illegal ops read nothing and write nothing
    o_dec.illegal = !known || bad_idx;
    if (o_dec.illegal) begin
      o_dec.rd_wen  = 1'b0;
      o_dec.rs1_ren = 1'b0;
      o_dec.rs2_ren = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hdl/int_alu.sv */
// int_alu: 64-bit add, subtract, logic, shift and compare
`timescale 1ns/1ps
`default_nettype none

module int_alu (
  input  core_pkg::alu_op_e           i_op,
  input  logic [rv_isa_pkg::XLEN-1:0] i_a,
  input  logic [rv_isa_pkg::XLEN-1:0] i_b,
  output logic [rv_isa_pkg::XLEN-1:0] o_result
);

  logic [5:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // RV64 shifts use six bits
  assign shamt       = i_b[5:0];
  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      core_pkg::ALU_ADD:    o_result = i_a + i_b;
      core_pkg::ALU_SUB:    o_result = i_a - i_b;
      core_pkg::ALU_SLL:    o_result = i_a << shamt;
      core_pkg::ALU_SLT:    o_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_signed};
      core_pkg::ALU_SLTU:   o_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_unsigned};
      core_pkg::ALU_XOR:    o_result = i_a ^ i_b;
      core_pkg::ALU_SRL:    o_result = i_a >> shamt;
      core_pkg::ALU_SRA:    o_result = $unsigned($signed(i_a) >>> shamt);
      core_pkg::ALU_OR:     o_result = i_a | i_b;
      core_pkg::ALU_AND:    o_result = i_a & i_b;
      // LUI passes the U-immediate through
      core_pkg::ALU_PASS_B: o_result = i_b;
      default:              o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/core_pkg.sv */
// micro-architecture types: ALU operation enum, decoded instruction and commit record
`default_nettype none

package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // output of stage 1, 88 bits
  typedef struct packed {
    alu_op_e                     alu_op;
    rv_isa_pkg::reg_idx_t        rs1;
    logic                        rs1_ren;
    rv_isa_pkg::reg_idx_t        rs2;
    logic                        rs2_ren;
    rv_isa_pkg::reg_idx_t        rd;
    logic                        rd_wen;
    logic                        use_imm;
    logic [rv_isa_pkg::XLEN-1:0] imm;
    logic                        illegal;
  } dec_t;

  // retired instruction, 71 bits
  typedef struct packed {
    rv_isa_pkg::reg_idx_t        rd;
    logic                        rd_wen;
    logic [rv_isa_pkg::XLEN-1:0] data;
    logic                        illegal;
  } commit_t;

endpackage

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
// RV64I ISA definitions: data width, register index, opcodes, funct fields, instruction union
`default_nettype none

package rv_isa_pkg;

  parameter int XLEN = 64;

  typedef logic [4:0] reg_idx_t;

  // major opcodes handled by this slice
  parameter logic [6:0] OPC_OP     = 7'b0110011;
  parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
  parameter logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 encodings shared by OP and OP-IMM
  parameter logic [2:0] F3_ADD_SUB = 3'b000;
  parameter logic [2:0] F3_SLL     = 3'b001;
  parameter logic [2:0] F3_SLT     = 3'b010;
  parameter logic [2:0] F3_SLTU    = 3'b011;
  parameter logic [2:0] F3_XOR     = 3'b100;
  parameter logic [2:0] F3_SRL_SRA = 3'b101;
  parameter logic [2:0] F3_OR      = 3'b110;
  parameter logic [2:0] F3_AND     = 3'b111;

  // funct7 values, alt selects SUB / SRA
  parameter logic [6:0] F7_BASE = 7'b0000000;
  parameter logic [6:0] F7_ALT  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_view_t;

  // U-immediate is {imm12, rs1, funct3} of the I view
  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
  } inst_u;

endpackage

`default_nettype wire
